// File: compile.f
+incdir+design
design/ecc_ic_pkg.sv
design/log_xbar.sv
design/ecc_bank_port.sv
design/ecc_err_regs.sv
design/ecc_interconnect.sv
test/tb_clk_gen.sv
test/ecc_interconnect_props.sv
test/tb_ecc_interconnect.sv

// File: Makefile
TOP = tb_ecc_interconnect

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Everything OK" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: test/tb_ecc_interconnect.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module tb_ecc_interconnect;

  import ecc_ic_pkg::*;

  localparam int n_window  = 32;                        // Words in use across all banks
  localparam int n_double  = 20;                        // Double-flip loads
  localparam int n_traffic = 300;                       // Cycles of random traffic
  localparam int max_wait  = 8;                         // Timeout for every wait loop
  localparam int bank_words = 2 ** (`ECC_ADDR_W - `ECC_BANK_SEL_W);

  logic        clk_i;
  logic        reset_i;
  logic        core_req    [`ECC_N_CORE];
  logic        core_we     [`ECC_N_CORE];
  addr_t       core_addr   [`ECC_N_CORE];
  data_t       core_wdata  [`ECC_N_CORE];
  logic        core_gnt    [`ECC_N_CORE];
  logic        core_rvalid [`ECC_N_CORE];
  data_t       core_rdata  [`ECC_N_CORE];
  logic        core_rerr   [`ECC_N_CORE];
  logic        mem_req     [`ECC_N_BANK];
  logic        mem_we      [`ECC_N_BANK];
  bank_addr_t  mem_addr    [`ECC_N_BANK];
  code_t       mem_wdata   [`ECC_N_BANK];
  code_t       mem_rdata   [`ECC_N_BANK];
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  data_t       pwdata;
  data_t       prdata;
  logic        pready;
  logic        pslverr;

  logic        pend_valid [`ECC_N_CORE];                // Request held until granted
  logic        pend_we    [`ECC_N_CORE];
  addr_t       pend_addr  [`ECC_N_CORE];
  data_t       pend_wdata [`ECC_N_CORE];
  code_t       pend_flip  [`ECC_N_CORE];                // Bits to invert on the load
  int          wait_cnt   [`ECC_N_CORE];
  logic        exp_rv     [`ECC_N_CORE];                // Response due this cycle
  logic        exp_load   [`ECC_N_CORE];
  data_t       exp_data   [`ECC_N_CORE];
  int          exp_flips  [`ECC_N_CORE];
  code_t       bank_mem   [`ECC_N_BANK][bank_words];    // Stored codewords
  logic        cap_req    [`ECC_N_BANK];                // Bank access seen before the edge
  logic        cap_we     [`ECC_N_BANK];
  bank_addr_t  cap_addr   [`ECC_N_BANK];
  code_t       cap_wdata  [`ECC_N_BANK];
  code_t       cap_flip   [`ECC_N_BANK];
  data_t       ref_mem    [2 ** `ECC_ADDR_W];           // Last data written per address
  err_cnt_t    model_corr;
  err_cnt_t    model_uncorr;
  logic [31:0] lfsr_state;
  addr_t       base;                                    // Start of the address window

  tb_clk_gen clk_gen_i (
    .clk_o ( clk_i )
  );

  ecc_interconnect ecc_interconnect_i (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .core_req_i    ( core_req    ),
    .core_we_i     ( core_we     ),
    .core_addr_i   ( core_addr   ),
    .core_wdata_i  ( core_wdata  ),
    .core_gnt_o    ( core_gnt    ),
    .core_rvalid_o ( core_rvalid ),
    .core_rdata_o  ( core_rdata  ),
    .core_rerr_o   ( core_rerr   ),
    .mem_req_o     ( mem_req     ),
    .mem_we_o      ( mem_we      ),
    .mem_addr_o    ( mem_addr    ),
    .mem_wdata_o   ( mem_wdata   ),
    .mem_rdata_i   ( mem_rdata   ),
    .paddr_i       ( paddr       ),
    .psel_i        ( psel        ),
    .penable_i     ( penable     ),
    .pwrite_i      ( pwrite      ),
    .pwdata_i      ( pwdata      ),
    .prdata_o      ( prdata      ),
    .pready_o      ( pready      ),
    .pslverr_o     ( pslverr     )
  );

  bind ecc_interconnect ecc_interconnect_props props_i (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .core_req_i    ( core_req_i    ),
    .core_addr_i   ( core_addr_i   ),
    .core_gnt_i    ( core_gnt_o    ),
    .core_rvalid_i ( core_rvalid_o ),
    .psel_i        ( psel_i        ),
    .penable_i     ( penable_i     ),
    .pready_i      ( pready_o      )
  );

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};                        // One step per bit
    end
    return v;
  endfunction

  function automatic addr_t pick_addr();
    return base + addr_t'(rand_bits($clog2(n_window)));
  endfunction

  function automatic err_cnt_t count_up(input err_cnt_t v);
    return (v == '1) ? v : v + err_cnt_t'(1);           // Sticks at all ones
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input err_cnt_t got, input err_cnt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input bank_addr_t got,
                            input bank_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Memory answers the last edge and cores drive on the falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      if (cap_req[b] && cap_we[b]) begin
        bank_mem[b][cap_addr[b]] = cap_wdata[b];
      end else if (cap_req[b]) begin
        mem_rdata[b] = bank_mem[b][cap_addr[b]] ^ cap_flip[b];  // Stored word untouched
      end
    end
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      core_req[c]   = pend_valid[c];
      core_we[c]    = pend_we[c];
      core_addr[c]  = pend_addr[c];
      core_wdata[c] = pend_wdata[c];
    end
  endtask

  task automatic check_responses();
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      check_flag($sformatf("core_rvalid_o[%0d]", c), core_rvalid[c], exp_rv[c]);
      if (exp_rv[c] && exp_load[c]) begin
        check_flag($sformatf("core_rerr_o[%0d]", c), core_rerr[c], exp_flips[c] == 2);
        if (exp_flips[c] < 2) begin                     // Data lost on two flips
          check_data($sformatf("core_rdata_o[%0d]", c), core_rdata[c], exp_data[c]);
        end
        if (exp_flips[c] == 1) model_corr = count_up(model_corr);
        if (exp_flips[c] == 2) model_uncorr = count_up(model_uncorr);
      end
      exp_rv[c] = 1'b0;
    end
  endtask

  task automatic capture_memory();
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      cap_req[b]   = mem_req[b];
      cap_we[b]    = mem_we[b];
      cap_addr[b]  = mem_addr[b];
      cap_wdata[b] = mem_wdata[b];
      cap_flip[b]  = '0;
    end
  endtask

  task automatic record_grants();
    logic [`ECC_BANK_SEL_W-1:0] bank;
    logic                       bank_wanted [`ECC_N_BANK];  // Some core aims at the bank
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      bank_wanted[b] = 1'b0;
    end
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      if (pend_valid[c]) bank_wanted[pend_addr[c][`ECC_BANK_SEL_W-1:0]] = 1'b1;
    end
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      check_flag($sformatf("mem_req_o[%0d]", b), mem_req[b], bank_wanted[b]);
    end
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      bank = pend_addr[c][`ECC_BANK_SEL_W-1:0];
      if (!pend_valid[c]) begin
        check_flag($sformatf("core_gnt_o[%0d]", c), core_gnt[c], 1'b0);
      end else if (core_gnt[c]) begin
        check_flag($sformatf("mem_we_o[%0d]", bank), mem_we[bank], pend_we[c]);
        check_addr($sformatf("mem_addr_o[%0d]", bank), mem_addr[bank],
                   pend_addr[c][`ECC_ADDR_W-1:`ECC_BANK_SEL_W]);  // Upper address bits
        exp_rv[c]    = 1'b1;
        exp_load[c]  = !pend_we[c];
        exp_data[c]  = ref_mem[pend_addr[c]];
        exp_flips[c] = pend_we[c] ? 0 : $countones(pend_flip[c]);
        if (pend_we[c]) ref_mem[pend_addr[c]] = pend_wdata[c];
        else cap_flip[bank] = pend_flip[c];
        pend_valid[c] = 1'b0;
        wait_cnt[c]   = 0;
      end else begin
        wait_cnt[c]++;                                  // Lost arbitration again
        if (wait_cnt[c] >= `ECC_N_CORE) begin
          abort_run($sformatf("Core %0d was not granted within %0d cycles",
                              c, `ECC_N_CORE));
        end
      end
    end
  endtask

  // Outputs are stable a little after the falling edge
  task automatic settle();
    #1;
    check_responses();
    capture_memory();
    record_grants();
  endtask

  task automatic step();
    next_cycle();
    settle();
  endtask

  task automatic single_access(input logic we, input addr_t addr, input data_t wdata,
                               input code_t flip);
    core_id_t c;
    int       waited;
    c             = core_id_t'(rand_bits(2));           // Any one core so nothing contends
    pend_valid[c] = 1'b1;
    pend_we[c]    = we;
    pend_addr[c]  = addr;
    pend_wdata[c] = wdata;
    pend_flip[c]  = flip;
    waited        = 0;
    while (pend_valid[c]) begin
      step();
      waited++;
      if (waited > max_wait) abort_run("A single access was never granted");
    end
    step();                                             // Response cycle
  endtask

  task automatic drain();
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy) begin
      step();
      busy = 1'b0;
      for (int c = 0; c < `ECC_N_CORE; c++) begin
        busy = busy | pend_valid[c] | exp_rv[c];
      end
      waited++;
      if (waited > max_wait) abort_run("Outstanding core requests did not complete");
    end
  endtask

  task automatic apb_access(input apb_addr_t addr, input logic write, input data_t wdata,
                            output data_t rdata, output logic slverr);
    int waited;
    next_cycle();
    psel    = 1'b1;                                     // Setup phase
    penable = 1'b0;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    settle();
    next_cycle();
    penable = 1'b1;                                     // Access phase
    settle();
    waited = 0;
    while (!pready) begin
      step();
      waited++;
      if (waited > max_wait) abort_run("APB access never saw pready");
    end
    rdata  = prdata;
    slverr = pslverr;
    if (write && addr == apb_addr_t'('h0)) model_corr = '0;
    if (write && addr == apb_addr_t'('h4)) model_uncorr = '0;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    settle();
  endtask

  task automatic read_counters();
    data_t rdata;
    logic  err;
    apb_access(apb_addr_t'('h0), 1'b0, '0, rdata, err);
    check_flag("pslverr_o", err, 1'b0);
    check_count("prdata_o (correctable count)", err_cnt_t'(rdata), model_corr);
    apb_access(apb_addr_t'('h4), 1'b0, '0, rdata, err);
    check_flag("pslverr_o", err, 1'b0);
    check_count("prdata_o (uncorrectable count)", err_cnt_t'(rdata), model_uncorr);
  endtask

  initial begin
    data_t rdata;
    logic  err;
    int    p1;
    int    p2;
    lfsr_state   = 32'h3c928b21;
    reset_i      = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    model_corr   = '0;
    model_uncorr = '0;
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      core_req[c]   = 1'b0;
      core_we[c]    = 1'b0;
      core_addr[c]  = '0;
      core_wdata[c] = '0;
      pend_valid[c] = 1'b0;
      pend_we[c]    = 1'b0;
      pend_addr[c]  = '0;
      pend_wdata[c] = '0;
      pend_flip[c]  = '0;
      wait_cnt[c]   = 0;
      exp_rv[c]     = 1'b0;
    end
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      mem_rdata[b] = '0;
      cap_req[b]   = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Fill the window and read it back clean
    base = addr_t'(rand_bits(`ECC_ADDR_W - $clog2(n_window)) << $clog2(n_window));
    for (int i = 0; i < n_window; i++) begin
      single_access(1'b1, base + addr_t'(i), rand_bits(32), '0);
    end
    for (int i = 0; i < n_window; i++) begin
      single_access(1'b0, base + addr_t'(i), '0, '0);
    end
    read_counters();

    // One flip at every codeword position
    for (int p = 0; p < `ECC_CODE_W; p++) begin
      single_access(1'b0, pick_addr(), '0, code_t'(1) << p);
    end
    read_counters();

    // Two distinct flips
    for (int i = 0; i < n_double; i++) begin
      p1 = int'(rand_bits(8)) % `ECC_CODE_W;
      p2 = (p1 + 1 + int'(rand_bits(8)) % (`ECC_CODE_W - 1)) % `ECC_CODE_W;
      single_access(1'b0, pick_addr(), '0, (code_t'(1) << p1) | (code_t'(1) << p2));
    end
    read_counters();

    // All cores at once with bank conflicts
    for (int t = 0; t < n_traffic; t++) begin
      for (int c = 0; c < `ECC_N_CORE; c++) begin
        if (!pend_valid[c] && rand_bits(2) != 0) begin
          pend_valid[c] = 1'b1;
          pend_we[c]    = lfsr_bit();
          pend_addr[c]  = pick_addr();
          pend_wdata[c] = rand_bits(32);
          pend_flip[c]  = '0;
        end
      end
      step();
    end
    drain();
    read_counters();

    // Unmapped addresses first and then each clear alone
    apb_access(apb_addr_t'('h8), 1'b1, rand_bits(32), rdata, err);
    check_flag("pslverr_o", err, 1'b1);
    apb_access(apb_addr_t'('hc), 1'b0, '0, rdata, err);
    check_flag("pslverr_o", err, 1'b1);
    read_counters();
    apb_access(apb_addr_t'('h0), 1'b1, rand_bits(32), rdata, err);
    check_flag("pslverr_o", err, 1'b0);
    read_counters();
    apb_access(apb_addr_t'('h4), 1'b1, rand_bits(32), rdata, err);
    check_flag("pslverr_o", err, 1'b0);
    read_counters();

    $display("Everything OK");
    $finish;
  end

endmodule

// File: test/ecc_interconnect_props.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module ecc_interconnect_props (
  input logic              clk_i,
  input logic              reset_i,
  input logic              core_req_i    [`ECC_N_CORE],
  input ecc_ic_pkg::addr_t core_addr_i   [`ECC_N_CORE],
  input logic              core_gnt_i    [`ECC_N_CORE],
  input logic              core_rvalid_i [`ECC_N_CORE],
  input logic              psel_i,
  input logic              penable_i,
  input logic              pready_i
);

  for (genvar c = 0; c < `ECC_N_CORE; c++) begin : gen_core
    assert property (@(posedge clk_i) disable iff (reset_i)
      core_gnt_i[c] |-> core_req_i[c])                  // Grant needs a live request
      else $error("Core %0d granted without a request", c);
    assert property (@(posedge clk_i) disable iff (reset_i)
      core_gnt_i[c] |=> core_rvalid_i[c])               // Response one cycle later
      else $error("Core %0d missed its response after a grant", c);
    assert property (@(posedge clk_i) disable iff (reset_i)
      core_rvalid_i[c] |-> $past(core_gnt_i[c]))        // No response out of nowhere
      else $error("Core %0d got a response without a grant", c);
  end

  // Two cores aimed at one bank never both win
  for (genvar c1 = 0; c1 < `ECC_N_CORE; c1++) begin : gen_pair_a
    for (genvar c2 = c1 + 1; c2 < `ECC_N_CORE; c2++) begin : gen_pair_b
      assert property (@(posedge clk_i) disable iff (reset_i)
        !(core_gnt_i[c1] && core_gnt_i[c2] &&
          (core_addr_i[c1][`ECC_BANK_SEL_W-1:0] == core_addr_i[c2][`ECC_BANK_SEL_W-1:0])))
        else $error("Cores %0d and %0d granted on one bank", c1, c2);
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (psel_i && penable_i) |-> pready_i)                 // No wait states
    else $error("APB access phase without pready");

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  localparam int half_period = 50;                      // 100 ns period

  initial begin
    clk_o = 1'b0;
  end

  always #half_period clk_o = ~clk_o;

endmodule

// File: design/ecc_interconnect.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module ecc_interconnect (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Cores
  input  logic                   core_req_i    [`ECC_N_CORE],
  input  logic                   core_we_i     [`ECC_N_CORE],
  input  ecc_ic_pkg::addr_t      core_addr_i   [`ECC_N_CORE],
  input  ecc_ic_pkg::data_t      core_wdata_i  [`ECC_N_CORE],
  output logic                   core_gnt_o    [`ECC_N_CORE],
  output logic                   core_rvalid_o [`ECC_N_CORE],
  output ecc_ic_pkg::data_t      core_rdata_o  [`ECC_N_CORE],
  output logic                   core_rerr_o   [`ECC_N_CORE],
  // Banks
  output logic                   mem_req_o     [`ECC_N_BANK],
  output logic                   mem_we_o      [`ECC_N_BANK],
  output ecc_ic_pkg::bank_addr_t mem_addr_o    [`ECC_N_BANK],
  output ecc_ic_pkg::code_t      mem_wdata_o   [`ECC_N_BANK],
  input  ecc_ic_pkg::code_t      mem_rdata_i   [`ECC_N_BANK],
  // APB
  input  ecc_ic_pkg::apb_addr_t  paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  ecc_ic_pkg::data_t      pwdata_i,
  output ecc_ic_pkg::data_t      prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  import ecc_ic_pkg::*;

  logic                   bank_req       [`ECC_N_BANK];  // Crossbar to bank port
  logic                   bank_we        [`ECC_N_BANK];
  bank_addr_t             bank_addr      [`ECC_N_BANK];
  data_t                  bank_wdata     [`ECC_N_BANK];
  logic                   bank_rsp_valid [`ECC_N_BANK];  // Bank port back to crossbar
  data_t                  bank_rdata     [`ECC_N_BANK];
  logic                   bank_rerr      [`ECC_N_BANK];
  logic [`ECC_N_BANK-1:0] corr_err;                      // Events to the counters
  logic [`ECC_N_BANK-1:0] uncorr_err;

  log_xbar i_log_xbar (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .core_req_i       ( core_req_i     ),
    .core_we_i        ( core_we_i      ),
    .core_addr_i      ( core_addr_i    ),
    .core_wdata_i     ( core_wdata_i   ),
    .core_gnt_o       ( core_gnt_o     ),
    .bank_req_o       ( bank_req       ),
    .bank_we_o        ( bank_we        ),
    .bank_addr_o      ( bank_addr      ),
    .bank_wdata_o     ( bank_wdata     ),
    .bank_rsp_valid_i ( bank_rsp_valid ),
    .bank_rdata_i     ( bank_rdata     ),
    .bank_rerr_i      ( bank_rerr      ),
    .core_rvalid_o    ( core_rvalid_o  ),
    .core_rdata_o     ( core_rdata_o   ),
    .core_rerr_o      ( core_rerr_o    )
  );

  for (genvar b = 0; b < `ECC_N_BANK; b++) begin : gen_bank_port
    ecc_bank_port i_ecc_bank_port (
      .clk_i        ( clk_i             ),
      .reset_i      ( reset_i           ),
      .req_i        ( bank_req[b]       ),
      .we_i         ( bank_we[b]        ),
      .addr_i       ( bank_addr[b]      ),
      .wdata_i      ( bank_wdata[b]     ),
      .mem_req_o    ( mem_req_o[b]      ),
      .mem_we_o     ( mem_we_o[b]       ),
      .mem_addr_o   ( mem_addr_o[b]     ),
      .mem_wdata_o  ( mem_wdata_o[b]    ),
      .mem_rdata_i  ( mem_rdata_i[b]    ),
      .rsp_valid_o  ( bank_rsp_valid[b] ),
      .rdata_o      ( bank_rdata[b]     ),
      .rerr_o       ( bank_rerr[b]      ),
      .corr_err_o   ( corr_err[b]       ),
      .uncorr_err_o ( uncorr_err[b]     )
    );
  end

  ecc_err_regs i_ecc_err_regs (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .corr_err_i   ( corr_err   ),
    .uncorr_err_i ( uncorr_err ),
    .paddr_i      ( paddr_i    ),
    .psel_i       ( psel_i     ),
    .penable_i    ( penable_i  ),
    .pwrite_i     ( pwrite_i   ),
    .pwdata_i     ( pwdata_i   ),
    .prdata_o     ( prdata_o   ),
    .pready_o     ( pready_o   ),
    .pslverr_o    ( pslverr_o  )
  );

endmodule

// File: design/ecc_err_regs.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module ecc_err_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Error events, one bit per bank
  input  logic [`ECC_N_BANK-1:0] corr_err_i,
  input  logic [`ECC_N_BANK-1:0] uncorr_err_i,
  // APB target
  input  ecc_ic_pkg::apb_addr_t paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  ecc_ic_pkg::data_t     pwdata_i,
  output ecc_ic_pkg::data_t     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  import ecc_ic_pkg::*;

  localparam apb_addr_t corr_addr   = 'h0;              // Correctable count
  localparam apb_addr_t uncorr_addr = 'h4;              // Uncorrectable count

  err_cnt_t corr_cnt_q;
  err_cnt_t uncorr_cnt_q;
  logic     access;                                     // APB access phase
  logic     hit_corr;
  logic     hit_uncorr;
  logic     clr_corr;
  logic     clr_uncorr;

  // Add the flagged banks, stick at all ones
  function automatic err_cnt_t sat_add(err_cnt_t cnt, logic [`ECC_N_BANK-1:0] flags);
    logic [`ECC_CNT_W:0] sum;
    sum = {1'b0, cnt};
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      sum = sum + flags[b];
    end
    return sum[`ECC_CNT_W] ? '1 : sum[`ECC_CNT_W-1:0];
  endfunction

  assign access     = psel_i && penable_i;
  assign hit_corr   = (paddr_i == corr_addr);
  assign hit_uncorr = (paddr_i == uncorr_addr);
  assign clr_corr   = access && pwrite_i && hit_corr;   // Written value is ignored
  assign clr_uncorr = access && pwrite_i && hit_uncorr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
    end else begin
      if (clr_corr) corr_cnt_q <= '0;                   // Clear wins over a new event
      else          corr_cnt_q <= sat_add(corr_cnt_q, corr_err_i);
      if (clr_uncorr) uncorr_cnt_q <= '0;
      else            uncorr_cnt_q <= sat_add(uncorr_cnt_q, uncorr_err_i);
    end
  end

  // Read mux, old value seen in the cycle of an event
  always_comb begin
    if (hit_uncorr) prdata_o = data_t'(uncorr_cnt_q);
    else if (hit_corr) prdata_o = data_t'(corr_cnt_q);
    else prdata_o = '0;
  end

  assign pready_o  = access;                            // No wait states
  assign pslverr_o = access && !(hit_corr || hit_uncorr);

endmodule

// File: design/ecc_bank_port.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module ecc_bank_port (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // From the crossbar
  input  logic                   req_i,
  input  logic                   we_i,
  input  ecc_ic_pkg::bank_addr_t addr_i,
  input  ecc_ic_pkg::data_t      wdata_i,
  // To the bank memory
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output ecc_ic_pkg::bank_addr_t mem_addr_o,
  output ecc_ic_pkg::code_t      mem_wdata_o,
  input  ecc_ic_pkg::code_t      mem_rdata_i,
  // Response and error events
  output logic                   rsp_valid_o,
  output ecc_ic_pkg::data_t      rdata_o,
  output logic                   rerr_o,
  output logic                   corr_err_o,
  output logic                   uncorr_err_o
);

  import ecc_ic_pkg::*;

  localparam int n_check = $clog2(`ECC_CODE_W - 1);     // 6 Hamming check bits

  logic                 rsp_q;                          // Any access last cycle
  logic                 rd_q;                           // Load last cycle
  logic [n_check-1:0]   syndrome;
  logic                 parity_odd;
  logic                 corr;
  logic                 uncorr;
  code_t                fixed;                          // Codeword after correction
  data_t                dec_data;

  // Extended Hamming, position p sits at bit p, overall parity at bit 0
  function automatic code_t ecc_encode(data_t d);
    code_t c;
    int    di;
    logic  par;
    c  = '0;
    di = 0;
    for (int p = 1; p < `ECC_CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin                     // Data at non powers of two
        c[p] = d[di];
        di++;
      end
    end
    for (int k = 0; k < n_check; k++) begin
      par = 1'b0;
      for (int p = 1; p < `ECC_CODE_W; p++) begin
        if (((p >> k) & 1) != 0) par ^= c[p];
      end
      c[1 << k] = par;
    end
    c[0] = ^c[`ECC_CODE_W-1:1];                         // Overall parity, even total
    return c;
  endfunction

  // Stores go out encoded, the memory sees every request as is
  assign mem_req_o   = req_i;
  assign mem_we_o    = we_i;
  assign mem_addr_o  = addr_i;
  assign mem_wdata_o = ecc_encode(wdata_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q <= 1'b0;
      rd_q  <= 1'b0;
    end else begin
      rsp_q <= req_i;
      rd_q  <= req_i && !we_i;
    end
  end

  // Decode in the response cycle
  always_comb begin
    int di;
    di = 0;
    for (int k = 0; k < n_check; k++) begin
      syndrome[k] = 1'b0;
      for (int p = 1; p < `ECC_CODE_W; p++) begin
        if (((p >> k) & 1) != 0) syndrome[k] ^= mem_rdata_i[p];
      end
    end
    parity_odd = ^mem_rdata_i;                          // Odd count means one flip
    fixed      = mem_rdata_i;
    corr       = 1'b0;
    uncorr     = 1'b0;
    if (parity_odd) begin
      if (syndrome == '0) begin
        corr = 1'b1;                                    // Only bit 0 was hit
      end else if (int'(syndrome) < `ECC_CODE_W) begin
        fixed[syndrome] = ~mem_rdata_i[syndrome];       // Flip the faulty position back
        corr = 1'b1;
      end else begin
        uncorr = 1'b1;                                  // Points past the codeword
      end
    end else if (syndrome != '0) begin
      uncorr = 1'b1;                                    // Two flips, parity even
    end
    dec_data = '0;
    for (int p = 1; p < `ECC_CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        dec_data[di] = fixed[p];
        di++;
      end
    end
  end

  assign rsp_valid_o  = rsp_q;
  assign rdata_o      = dec_data;
  assign corr_err_o   = rd_q && corr;                   // Stores leave no read event
  assign uncorr_err_o = rd_q && uncorr;
  assign rerr_o       = rd_q && uncorr;

endmodule

// File: design/log_xbar.sv
`timescale 1ns/1ps

`include "ecc_ic_defs.svh"

module log_xbar (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Core requests
  input  logic                   core_req_i       [`ECC_N_CORE],
  input  logic                   core_we_i        [`ECC_N_CORE],
  input  ecc_ic_pkg::addr_t      core_addr_i      [`ECC_N_CORE],
  input  ecc_ic_pkg::data_t      core_wdata_i     [`ECC_N_CORE],
  output logic                   core_gnt_o       [`ECC_N_CORE],
  // Bank requests
  output logic                   bank_req_o       [`ECC_N_BANK],
  output logic                   bank_we_o        [`ECC_N_BANK],
  output ecc_ic_pkg::bank_addr_t bank_addr_o      [`ECC_N_BANK],
  output ecc_ic_pkg::data_t      bank_wdata_o     [`ECC_N_BANK],
  // Bank responses
  input  logic                   bank_rsp_valid_i [`ECC_N_BANK],
  input  ecc_ic_pkg::data_t      bank_rdata_i     [`ECC_N_BANK],
  input  logic                   bank_rerr_i      [`ECC_N_BANK],
  // Core responses
  output logic                   core_rvalid_o    [`ECC_N_CORE],
  output ecc_ic_pkg::data_t      core_rdata_o     [`ECC_N_CORE],
  output logic                   core_rerr_o      [`ECC_N_CORE]
);

  import ecc_ic_pkg::*;

  logic [`ECC_BANK_SEL_W-1:0] core_bank [`ECC_N_CORE];  // Target bank per core
  logic [`ECC_N_CORE-1:0]     bank_hits [`ECC_N_BANK];  // Requesting cores per bank
  core_id_t                   win       [`ECC_N_BANK];  // Arbitration winner
  core_id_t                   rr_ptr_q  [`ECC_N_BANK];  // Highest priority core
  core_id_t                   owner_q   [`ECC_N_BANK];  // Core owed a response

  // First requester at or after ptr, wrapping around
  function automatic core_id_t rr_pick(logic [`ECC_N_CORE-1:0] req, core_id_t ptr);
    core_id_t idx;
    core_id_t pick;
    logic     found;
    pick  = ptr;
    found = 1'b0;
    for (int k = 0; k < `ECC_N_CORE; k++) begin
      idx = ptr + core_id_t'(k);                        // Wraps on the 2-bit index
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // Bank decode from the low address bits
  always_comb begin
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      core_bank[c] = core_addr_i[c][`ECC_BANK_SEL_W-1:0];
    end
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      for (int c = 0; c < `ECC_N_CORE; c++) begin
        bank_hits[b][c] = core_req_i[c] && (int'(core_bank[c]) == b);
      end
    end
  end

  // Per-bank arbitration and forwarding of the winner's fields
  always_comb begin
    for (int b = 0; b < `ECC_N_BANK; b++) begin
      win[b]          = rr_pick(bank_hits[b], rr_ptr_q[b]);
      bank_req_o[b]   = |bank_hits[b];
      bank_we_o[b]    = core_we_i[win[b]];
      bank_addr_o[b]  = core_addr_i[win[b]][`ECC_ADDR_W-1:`ECC_BANK_SEL_W];  // Drop bank bits
      bank_wdata_o[b] = core_wdata_i[win[b]];
    end
  end

  // Grant back to the core that won its bank, same cycle
  always_comb begin
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      core_gnt_o[c] = core_req_i[c] && (win[core_bank[c]] == core_id_t'(c));
    end
  end

  // Pointer moves past the winner, owner kept for the response cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int b = 0; b < `ECC_N_BANK; b++) begin
        rr_ptr_q[b] <= '0;                              // Core 0 first after reset
        owner_q[b]  <= '0;
      end
    end else begin
      for (int b = 0; b < `ECC_N_BANK; b++) begin
        if (bank_req_o[b]) begin
          rr_ptr_q[b] <= win[b] + 1'b1;
          owner_q[b]  <= win[b];
        end
      end
    end
  end

  // Response routing, a core owns at most one bank per cycle
  always_comb begin
    for (int c = 0; c < `ECC_N_CORE; c++) begin
      core_rvalid_o[c] = 1'b0;
      core_rdata_o[c]  = '0;
      core_rerr_o[c]   = 1'b0;
      for (int b = 0; b < `ECC_N_BANK; b++) begin
        if (bank_rsp_valid_i[b] && (owner_q[b] == core_id_t'(c))) begin
          core_rvalid_o[c] = 1'b1;
          core_rdata_o[c]  = bank_rdata_i[b];
          core_rerr_o[c]   = bank_rerr_i[b];
        end
      end
    end
  end

endmodule

// File: design/ecc_ic_pkg.sv
`include "ecc_ic_defs.svh"

package ecc_ic_pkg;

  // Core word address, bank select sits in the low bits
  typedef logic [`ECC_ADDR_W-1:0] addr_t;

  // Word index inside one bank
  typedef logic [`ECC_ADDR_W-`ECC_BANK_SEL_W-1:0] bank_addr_t;

  // Plain data word as seen by the cores
  typedef logic [`ECC_DATA_W-1:0] data_t;

  // Stored codeword, bit 0 holds overall parity
  typedef logic [`ECC_CODE_W-1:0] code_t;

  // Core index, also the round-robin pointer
  typedef logic [$clog2(`ECC_N_CORE)-1:0] core_id_t;

  // Error event counter
  typedef logic [`ECC_CNT_W-1:0] err_cnt_t;

  // APB register address
  typedef logic [`ECC_APB_AW-1:0] apb_addr_t;

endpackage

// File: design/ecc_ic_defs.svh
`ifndef ECC_IC_DEFS_SVH
`define ECC_IC_DEFS_SVH

// Cluster shape
`define ECC_N_CORE      4   // Initiator cores
`define ECC_N_BANK      4   // Word-interleaved banks

// Address split, bank select in the low bits
`define ECC_ADDR_W      12  // Core word address
`define ECC_BANK_SEL_W  2   // Low address bits picking the bank

// Data path and SECDED codeword
`define ECC_DATA_W      32  // Payload word
`define ECC_CODE_W      39  // 32 data + 6 Hamming + 1 overall parity

// Error counters and their APB window
`define ECC_CNT_W       16  // Saturating counter width
`define ECC_APB_AW      4   // Register address width

`endif
